//--- hdl/branch_cond.sv
// Branch condition test on operand A keyed by the low
// four opcode bits
`include "ebox_cfg.svh"

module branch_cond (
  input  isa_pkg::opcode_t       opcode,
  input  logic [`EBOX_XLEN-1:0] reg_a,
  output logic                  taken
);

  logic neg;
  logic zero;

  assign neg  = reg_a[`EBOX_XLEN-1];
  assign zero = ~|reg_a;

  always_comb begin
    case (opcode[3:0])
      4'd0, 4'd4: taken = 1'b1;     // BR, BSR
      4'd8:       taken = ~reg_a[0];  // BLBC
      4'd9:       taken = zero;       // BEQ
      4'd10:      taken = neg;        // BLT
      4'd11:      taken = neg | zero;  // BLE
      4'd12:      taken = reg_a[0];   // BLBS
      4'd13:      taken = ~zero;      // BNE
      4'd14:      taken = ~neg;       // BGE
      4'd15:      taken = ~neg & ~zero;  // BGT
      default:    taken = 1'b0;       // FP branches not handled here
    endcase
  end

endmodule

//--- hdl/ebox_cfg.svh
// Execute unit configuration macros for data and instruction widths,
// later-stage count and reset PC
`ifndef EBOX_CFG_SVH
`define EBOX_CFG_SVH

// Data path and address width
`define EBOX_XLEN 64

// Instruction word width
`define EBOX_INST_W 32

// Stages after issue: execute, memory, writeback
`define EBOX_N_STAGES 3

// First fetch address
`define EBOX_RESET_PC 64'h0

`endif

//--- hdl/ebox_top.sv
// Execute unit control top with the issue controller, later stage
// chain and forwarding selector
`include "ebox_cfg.svh"

module ebox_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`EBOX_INST_W-1:0] inst,
  input  logic [`EBOX_XLEN-1:0]   reg_a,
  input  logic [`EBOX_XLEN-1:0]   reg_b,
  input  logic                    i_stall,
  input  logic                    d_stall,
  output logic [`EBOX_XLEN-1:0]   pc,
  output isa_pkg::reg_addr_t      ra_addr,
  output isa_pkg::reg_addr_t      rb_addr,
  output logic [7:0]              literal,
  output logic [15:0]             displacement,
  output pipe_pkg::fwd_sel_t      fwd_a_sel,
  output pipe_pkg::fwd_sel_t      fwd_b_sel,
  output logic                    reg_w,
  output isa_pkg::reg_addr_t      wb_addr
);
  import pipe_pkg::*;

  stage_rec_t                issue_rec;
  stage_rec_t                stage_in  [`EBOX_N_STAGES];
  stage_rec_t                stage_rec [`EBOX_N_STAGES];
  logic [`EBOX_N_STAGES-1:0] hit_a;
  logic [`EBOX_N_STAGES-1:0] hit_b;
  logic                      load_use;

  issue_ctrl u_issue_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .i_stall      (i_stall),
    .d_stall      (d_stall),
    .load_use     (load_use),
    .pc           (pc),
    .ra_addr      (ra_addr),
    .rb_addr      (rb_addr),
    .literal      (literal),
    .displacement (displacement),
    .issue_rec    (issue_rec)
  );

  for (genvar i = 0; i < `EBOX_N_STAGES; i++) begin : g_stage
    if (i == 0) begin : g_head
      assign stage_in[i] = issue_rec;
    end else begin : g_link
      assign stage_in[i] = stage_rec[i-1];
    end

    pipe_stage u_stage (
      .clk     (clk),
      .rst_n   (rst_n),
      .d_stall (d_stall),
      .rec_in  (stage_in[i]),
      .ra_addr (ra_addr),
      .rb_addr (rb_addr),
      .rec     (stage_rec[i]),
      .hit_a   (hit_a[i]),
      .hit_b   (hit_b[i])
    );
  end

  fwd_select u_fwd_select (
    .recs      (stage_rec),
    .hit_a     (hit_a),
    .hit_b     (hit_b),
    .fwd_a_sel (fwd_a_sel),
    .fwd_b_sel (fwd_b_sel),
    .load_use  (load_use),
    .reg_w     (reg_w),
    .wb_addr   (wb_addr)
  );

  // After a load-use hold the load sits in memory, never in execute
  a_no_load_ex_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    load_use && !d_stall |=> fwd_a_sel != FWD_EX && fwd_b_sel != FWD_EX);

endmodule

//--- hdl/fwd_select.sv
// Forwarding priority for both sources, load-use detection
// and write-back outputs
`include "ebox_cfg.svh"

module fwd_select (
  input  pipe_pkg::stage_rec_t      recs [`EBOX_N_STAGES],
  input  logic [`EBOX_N_STAGES-1:0] hit_a,
  input  logic [`EBOX_N_STAGES-1:0] hit_b,
  output pipe_pkg::fwd_sel_t        fwd_a_sel,
  output pipe_pkg::fwd_sel_t        fwd_b_sel,
  output logic                      load_use,
  output logic                      reg_w,
  output isa_pkg::reg_addr_t        wb_addr
);
  import pipe_pkg::*;

  // Oldest stage first so the nearest hit overwrites it
  function automatic fwd_sel_t pick(logic [`EBOX_N_STAGES-1:0] hit, logic ex_load);
    fwd_sel_t sel;
    sel = FWD_RF;
    for (int i = `EBOX_N_STAGES - 1; i >= 0; i--) begin
      if (hit[i] && !(i == 0 && ex_load)) begin
        sel = fwd_sel_t'(i + 1);
      end
    end
    return sel;
  endfunction

  // Load data only exists from the memory stage on
  assign fwd_a_sel = pick(hit_a, recs[0].is_load);
  assign fwd_b_sel = pick(hit_b, recs[0].is_load);

  assign load_use = recs[0].is_load && (hit_a[0] || hit_b[0]);

  assign reg_w   = recs[`EBOX_N_STAGES-1].writes_reg;
  assign wb_addr = recs[`EBOX_N_STAGES-1].dest;

endmodule

//--- hdl/isa_pkg.sv
// Alpha integer ISA field types, opcode constants
// and opcode class helpers
`include "ebox_cfg.svh"

package isa_pkg;

  typedef logic [4:0] reg_addr_t;
  typedef logic [5:0] opcode_t;
  typedef logic [`EBOX_INST_W-1:0] inst_t;

  localparam reg_addr_t REG_ZERO = 5'd31;  // Reads as zero, writes dropped

  localparam opcode_t OP_INTA = 6'h10;  // Integer arithmetic
  localparam opcode_t OP_INTL = 6'h11;  // Integer logical
  localparam opcode_t OP_INTS = 6'h12;  // Shift and byte manipulation
  localparam opcode_t OP_INTM = 6'h13;  // Integer multiply
  localparam opcode_t OP_FPTI = 6'h1C;  // Sign extend and count ops
  localparam opcode_t OP_JMP  = 6'h1A;  // JMP, JSR, RET, JSR_COROUTINE

  function automatic opcode_t get_opcode(inst_t inst);
    return inst[31:26];
  endfunction

  function automatic reg_addr_t get_ra(inst_t inst);
    return inst[25:21];
  endfunction

  function automatic reg_addr_t get_rb(inst_t inst);
    return inst[20:16];
  endfunction

  function automatic reg_addr_t get_rc(inst_t inst);
    return inst[4:0];
  endfunction

  function automatic logic [7:0] get_literal(inst_t inst);
    return inst[20:13];
  endfunction

  function automatic logic [15:0] get_disp(inst_t inst);
    return inst[15:0];
  endfunction

  function automatic logic [20:0] get_br_disp(inst_t inst);
    return inst[20:0];
  endfunction

  // LDA..LDWU and LDL..LDQ_L
  function automatic logic is_load(opcode_t op);
    return (op >= 6'h08 && op <= 6'h0C) || (op >= 6'h28 && op <= 6'h2B);
  endfunction

  function automatic logic is_operate(opcode_t op);
    return op inside {OP_INTA, OP_INTL, OP_INTS, OP_INTM, OP_FPTI};
  endfunction

  // All of 30..3F hex are branch format
  function automatic logic is_branch(opcode_t op);
    return op[5:4] == 2'b11;
  endfunction

endpackage

//--- hdl/issue_ctrl.sv
// Program counter, next-PC selection, issue instruction register
// and decode of the record leaving issue
`include "ebox_cfg.svh"

module issue_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`EBOX_INST_W-1:0] inst,
  input  logic [`EBOX_XLEN-1:0]   reg_a,
  input  logic [`EBOX_XLEN-1:0]   reg_b,
  input  logic                   i_stall,
  input  logic                   d_stall,
  input  logic                   load_use,
  output logic [`EBOX_XLEN-1:0]   pc,
  output isa_pkg::reg_addr_t      ra_addr,
  output isa_pkg::reg_addr_t      rb_addr,
  output logic [7:0]             literal,
  output logic [15:0]            displacement,
  output pipe_pkg::stage_rec_t    issue_rec
);
  import isa_pkg::*;

  inst_t                  ir;  // Issue instruction register
  opcode_t                op;
  logic                   jump;
  logic                   branch;
  logic                   taken;
  logic [20:0]            br_disp;
  logic [`EBOX_XLEN-1:0]  br_target;
  logic [`EBOX_XLEN-1:0]  jmp_target;
  reg_addr_t              dest;
  logic                   writes;

  assign op           = get_opcode(ir);
  assign jump         = (op == OP_JMP);
  assign branch       = is_branch(op);
  assign ra_addr      = get_ra(ir);
  assign rb_addr      = get_rb(ir);
  assign literal      = get_literal(ir);
  assign displacement = get_disp(ir);
  assign br_disp      = get_br_disp(ir);

  // Word displacement, sign extended
  assign br_target  = pc + {{(`EBOX_XLEN-23){br_disp[20]}}, br_disp, 2'b00};
  assign jmp_target = {reg_b[`EBOX_XLEN-1:2], 2'b00};

  branch_cond u_branch_cond (
    .opcode (op),
    .reg_a  (reg_a),
    .taken  (taken)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `EBOX_RESET_PC;
      ir <= '0;
    end else if (d_stall || load_use) begin
      pc <= pc;  // Whole front end frozen
      ir <= ir;
    end else if (jump) begin
      pc <= jmp_target;
      ir <= '0;
    end else if (branch) begin
      if (taken) begin
        pc <= br_target;
      end
      ir <= '0;  // Fetched slot is discarded either way
    end else if (i_stall) begin
      ir <= '0;
    end else begin
      pc <= pc + `EBOX_XLEN'd4;
      ir <= inst;
    end
  end

  // Operate writes rc; loads and jumps write ra
  assign dest   = is_operate(op) ? get_rc(ir) : get_ra(ir);
  assign writes = (is_operate(op) || is_load(op) || jump) && (dest != REG_ZERO);

  always_comb begin
    issue_rec = '0;
    if (!load_use) begin  // Held instruction sends a bubble instead
      issue_rec.dest       = dest;
      issue_rec.writes_reg = writes;
      issue_rec.is_load    = is_load(op);
      issue_rec.is_jump    = jump;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00);

  // Operand A must be settled whenever a branch decides the next PC
  a_taken_known: assert property (@(posedge clk) disable iff (!rst_n)
    branch && !d_stall && !load_use |-> !$isunknown(taken));

endmodule

//--- hdl/pipe_pkg.sv
// Stage record carried down the later pipeline stages
// and operand forwarding select encoding

package pipe_pkg;

  // All-zero record is a bubble
  typedef struct packed {
    isa_pkg::reg_addr_t dest;        // Destination register
    logic               writes_reg;  // Clear when dest is the zero register
    logic               is_load;     // Result not ready before memory stage
    logic               is_jump;     // Writes the return address
  } stage_rec_t;

  localparam stage_rec_t REC_BUBBLE = '0;

  // Where an issue-stage operand is taken from
  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,  // Register file
    FWD_EX  = 2'd1,  // Execute stage result
    FWD_MEM = 2'd2,  // Memory stage result
    FWD_WB  = 2'd3   // Writeback stage result
  } fwd_sel_t;

endpackage

//--- hdl/pipe_stage.sv
// One later pipeline stage with its record register and source
// register match for forwarding

module pipe_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 d_stall,
  input  pipe_pkg::stage_rec_t rec_in,
  input  isa_pkg::reg_addr_t   ra_addr,
  input  isa_pkg::reg_addr_t   rb_addr,
  output pipe_pkg::stage_rec_t rec,
  output logic                 hit_a,
  output logic                 hit_b
);
  import pipe_pkg::*;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rec <= REC_BUBBLE;
    end else if (!d_stall) begin
      rec <= rec_in;
    end
  end

  // writes_reg is never set for register 31
  assign hit_a = rec.writes_reg && (rec.dest == ra_addr);
  assign hit_b = rec.writes_reg && (rec.dest == rb_addr);

endmodule

//--- project.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/branch_cond.sv
hdl/issue_ctrl.sv
hdl/pipe_stage.sv
hdl/fwd_select.sv
hdl/ebox_top.sv
test/clk_gen.sv
test/tb_ebox.sv

//--- test/clk_gen.sv
// Testbench clock source and synchronous reset
// held low for a fixed number of cycles

module clk_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;  // Released just after the last reset edge
  end

endmodule

//--- test/tb_ebox.sv
// Execute unit control testbench with program memory, random stimulus,
// shadow pipeline reference model, per-cycle comparison and watchdog
`include "ebox_cfg.svh"

module tb_ebox;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int     clk_period = 8;
  localparam int     n_cycles   = 2000;
  localparam int     mem_depth  = 256;
  localparam longint timeout    = (n_cycles + 3 + 100) * clk_period;

  logic                    clk;
  logic                    rst_n;
  logic [`EBOX_INST_W-1:0] inst;
  logic [`EBOX_XLEN-1:0]   reg_a;
  logic [`EBOX_XLEN-1:0]   reg_b;
  logic                    i_stall;
  logic                    d_stall;
  logic [`EBOX_XLEN-1:0]   pc;
  reg_addr_t               ra_addr;
  reg_addr_t               rb_addr;
  logic [7:0]              literal;
  logic [15:0]             displacement;
  fwd_sel_t                fwd_a_sel;
  fwd_sel_t                fwd_b_sel;
  logic                    reg_w;
  reg_addr_t               wb_addr;

  logic [`EBOX_INST_W-1:0] prog_mem [mem_depth];
  logic [`EBOX_XLEN-1:0]   sh_pc;  // Shadow state of the reference model
  logic [`EBOX_INST_W-1:0] sh_ir;
  stage_rec_t              sh_rec [`EBOX_N_STAGES];
  logic                    model_valid = 1'b0;
  int                      errors = 0;
  int                      checks = 0;

  clk_gen #(.period(clk_period), .reset_cycles(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  ebox_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .i_stall      (i_stall),
    .d_stall      (d_stall),
    .pc           (pc),
    .ra_addr      (ra_addr),
    .rb_addr      (rb_addr),
    .literal      (literal),
    .displacement (displacement),
    .fwd_a_sel    (fwd_a_sel),
    .fwd_b_sel    (fwd_b_sel),
    .reg_w        (reg_w),
    .wb_addr      (wb_addr)
  );

  // Small register set so that forwarding hits are frequent
  function automatic reg_addr_t pick_reg();
    int unsigned r;
    r = $urandom % 5;
    return (r == 4) ? 5'd31 : reg_addr_t'(r);
  endfunction

  function automatic logic [31:0] make_inst();
    int unsigned kind;
    logic [31:0] w;
    logic [5:0]  op;
    kind = $urandom % 16;
    w    = $urandom;
    if (kind < 8) begin
      op = ($urandom % 5 == 4) ? 6'h1C : 6'h10 + 6'($urandom % 4);  // Operate
    end else if (kind < 11) begin
      op = ($urandom % 2) ? 6'h08 + 6'($urandom % 5) : 6'h28 + 6'($urandom % 4);
    end else if (kind < 12) begin
      op = 6'h1A;
    end else begin
      op = {2'b11, 4'($urandom)};  // Any branch code
    end
    w[31:26] = op;
    w[25:21] = pick_reg();
    w[20:16] = pick_reg();
    w[4:0]   = pick_reg();
    return w;
  endfunction

  function automatic logic cond_taken(logic [3:0] code, logic [`EBOX_XLEN-1:0] a);
    logic neg;
    logic zero;
    neg  = a[`EBOX_XLEN-1];
    zero = (a == '0);
    case (code)
      4'd0, 4'd4: return 1'b1;
      4'd8:       return !a[0];
      4'd12:      return a[0];
      4'd9:       return zero;
      4'd13:      return !zero;
      4'd10:      return neg;
      4'd11:      return neg || zero;
      4'd14:      return !neg;
      4'd15:      return !neg && !zero;
      default:    return 1'b0;
    endcase
  endfunction

  function automatic stage_rec_t decode_rec(logic [31:0] ir);
    logic [5:0] op;
    logic       oper;
    logic       ld;
    stage_rec_t r;
    op   = ir[31:26];
    oper = op inside {6'h10, 6'h11, 6'h12, 6'h13, 6'h1C};
    ld   = (op >= 6'h08 && op <= 6'h0C) || (op >= 6'h28 && op <= 6'h2B);
    r.dest       = oper ? ir[4:0] : ir[25:21];
    r.writes_reg = (oper || ld || op == 6'h1A) && (r.dest != 5'd31);
    r.is_load    = ld;
    r.is_jump    = (op == 6'h1A);
    return r;
  endfunction

  // Nearest writer first; a load in execute has no data yet
  function automatic fwd_sel_t nearest_src(reg_addr_t src);
    fwd_sel_t sel;
    sel = FWD_RF;
    for (int i = 0; i < `EBOX_N_STAGES; i++) begin
      if (sel == FWD_RF && src != 5'd31 && sh_rec[i].writes_reg && sh_rec[i].dest == src
          && !(i == 0 && sh_rec[0].is_load)) begin
        sel = fwd_sel_t'(i + 1);
      end
    end
    return sel;
  endfunction

  function automatic logic load_use_now();
    return sh_rec[0].is_load && sh_rec[0].writes_reg &&
           (sh_rec[0].dest == sh_ir[25:21] || sh_rec[0].dest == sh_ir[20:16]);
  endfunction

  function automatic void step_model();
    logic [5:0]  op;
    logic        lu;
    logic [20:0] bd;
    stage_rec_t  head;
    op   = sh_ir[31:26];
    lu   = load_use_now();
    head = lu ? stage_rec_t'('0) : decode_rec(sh_ir);
    for (int i = `EBOX_N_STAGES - 1; i > 0; i--) begin
      sh_rec[i] = sh_rec[i-1];
    end
    sh_rec[0] = head;
    if (!lu) begin  // Load-use keeps pc and issue register
      if (op == 6'h1A) begin
        sh_pc = {reg_b[`EBOX_XLEN-1:2], 2'b00};
        sh_ir = '0;
      end else if (op[5:4] == 2'b11) begin
        bd = sh_ir[20:0];
        if (cond_taken(op[3:0], reg_a)) begin
          sh_pc = sh_pc + {{(`EBOX_XLEN-23){bd[20]}}, bd, 2'b00};
        end
        sh_ir = '0;
      end else if (i_stall) begin
        sh_ir = '0;
      end else begin
        sh_pc = sh_pc + 4;
        sh_ir = inst;
      end
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic compare_outputs();
    stage_rec_t last;
    last = sh_rec[`EBOX_N_STAGES-1];
    checks++;
    if (pc !== sh_pc) report_mismatch("pc", pc, sh_pc);
    if (ra_addr !== sh_ir[25:21]) report_mismatch("ra_addr", ra_addr, sh_ir[25:21]);
    if (rb_addr !== sh_ir[20:16]) report_mismatch("rb_addr", rb_addr, sh_ir[20:16]);
    if (literal !== sh_ir[20:13]) report_mismatch("literal", literal, sh_ir[20:13]);
    if (displacement !== sh_ir[15:0]) report_mismatch("displacement", displacement, sh_ir[15:0]);
    if (fwd_a_sel !== nearest_src(sh_ir[25:21]))
      report_mismatch("fwd_a_sel", fwd_a_sel, nearest_src(sh_ir[25:21]));
    if (fwd_b_sel !== nearest_src(sh_ir[20:16]))
      report_mismatch("fwd_b_sel", fwd_b_sel, nearest_src(sh_ir[20:16]));
    if (reg_w !== last.writes_reg) report_mismatch("reg_w", reg_w, last.writes_reg);
    if (last.writes_reg && wb_addr !== last.dest) report_mismatch("wb_addr", wb_addr, last.dest);
  endtask

  task automatic drive_inputs(input logic allow_stall);
    inst    = prog_mem[pc[9:2]];
    reg_a   = ($urandom % 4 == 0) ? '0 : {$urandom, $urandom};
    reg_b   = {$urandom, $urandom};
    i_stall = allow_stall && ($urandom % 8 == 0);
    d_stall = allow_stall && ($urandom % 8 == 0);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      sh_pc       = `EBOX_RESET_PC;
      sh_ir       = '0;
      sh_rec      = '{default: '0};
      model_valid = 1'b1;
    end else if (model_valid && !d_stall) begin
      step_model();
    end
  end

  always @(negedge clk) begin
    if (model_valid) compare_outputs();  // Outputs settled mid-cycle
  end

  initial begin
    inst    = '0;
    reg_a   = '0;
    reg_b   = '0;
    i_stall = 1'b0;
    d_stall = 1'b0;
    void'($urandom(32'hffeb33e1));
    for (int i = 0; i < mem_depth; i++) begin
      prog_mem[i] = make_inst();
    end
    @(posedge rst_n);
    for (int c = 0; c < n_cycles; c++) begin
      drive_inputs(c >= 16);  // Stall-free start
      @(posedge clk);
      #1;
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(timeout);
    $display("timeout: run still going after %0d time units", timeout);
    $display("Testbench failed");
    $finish;
  end

endmodule
